// File: hdl/dpa_pkg.sv
package dpa_pkg;

    // memory ports
    localparam int IM_ADDR_W = 20;
    localparam int IM_DATA_W = 24;
    localparam int CR_ADDR_W = 9;
    localparam int GLYPH_W   = 13;   // pixels per glyph row, also ROM word

    typedef logic [IM_DATA_W-1:0] pixel_t;
    typedef logic [IM_ADDR_W-1:0] im_addr_t;

    // character ROM layout, digits 0..9 then the colon
    localparam int GLYPH_ROWS     = 24;
    localparam int GLYPH_COLON    = 10;
    localparam int CHARS_PER_TIME = 8;    // hh:mm:ss

    // frame buffer geometry
    localparam int FB_WIDTH = 256;
    localparam int TIME_ROW = 8;
    localparam int TIME_COL = 8;

    // short second so that simulation stays practical
    localparam int CYCLES_PER_SECOND = 4000;
    localparam int HEADER_WORDS      = 2;

    localparam pixel_t PIXEL_ON  = '1;
    localparam pixel_t PIXEL_OFF = '0;

    // counter widths
    localparam int HDR_CNT_W   = $clog2(HEADER_WORDS + 1);
    localparam int TICK_CNT_W  = $clog2(CYCLES_PER_SECOND);
    localparam int GLYPH_IDX_W = $clog2(GLYPH_COLON + 1);
    localparam int CHAR_CNT_W  = $clog2(CHARS_PER_TIME);
    localparam int ROW_CNT_W   = $clog2(GLYPH_ROWS);
    localparam int BIT_CNT_W   = $clog2(GLYPH_W);

    typedef struct packed {
        logic [7:0] hour;
        logic [7:0] minute;
        logic [7:0] second;
    } time_t;

    // word 1 of the header, base address in the low bits
    typedef struct packed {
        logic [IM_DATA_W-IM_ADDR_W-1:0] pad;
        im_addr_t                       addr;
    } header_addr_t;

    // one header word, read as a time (word 0) or as an address (word 1)
    typedef union packed {
        time_t        tm;
        header_addr_t ad;
    } header_word_u;

endpackage

// File: hdl/header_decode.sv
`timescale 1ns/100ps

module header_decode
    import dpa_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  pixel_t   im_q,
    output im_addr_t hdr_a,
    output logic     hdr_wen,
    output logic     header_done,
    output time_t    init_time,
    output im_addr_t fb_base
);

    logic [HDR_CNT_W-1:0] fetch_cnt;   // next header address
    logic [HDR_CNT_W-1:0] rd_idx;      // address of the word now on im_q
    logic                 rd_valid;
    header_word_u         hdr_word;

    assign hdr_word = im_q;
    assign hdr_a    = im_addr_t'(fetch_cnt);
    assign hdr_wen  = 1'b1;   // header port only ever reads

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fetch_cnt   <= '0;
            rd_idx      <= '0;
            rd_valid    <= 1'b0;
            header_done <= 1'b0;
        end else begin
            if (fetch_cnt != HDR_CNT_W'(HEADER_WORDS)) begin
                fetch_cnt <= fetch_cnt + 1'b1;
            end
            // memory answers one cycle after the address
            rd_valid <= (fetch_cnt != HDR_CNT_W'(HEADER_WORDS));
            rd_idx   <= fetch_cnt;
            if (rd_valid && rd_idx == HDR_CNT_W'(HEADER_WORDS - 1)) begin
                header_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            if (rd_idx == '0) begin
                init_time <= hdr_word.tm;
            end else if (rd_idx == HDR_CNT_W'(1)) begin
                fb_base <= hdr_word.ad.addr;
            end
        end
    end

endmodule

// File: hdl/time_keeper.sv
`timescale 1ns/100ps

module time_keeper
    import dpa_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  header_done,
    input  time_t init_time,
    output logic  sec_tick,
    output time_t cur_time
);

    logic                  header_done_d;
    logic                  load;
    logic [TICK_CNT_W-1:0] tick_cnt;   // cycles since the last second
    time_t                 time_r;
    time_t                 time_next;

    assign load = header_done & ~header_done_d;

    // start time shows through in the load cycle so the first frame sees it
    assign cur_time = load ? init_time : time_r;

    always_comb begin
        time_next = time_r;
        if (time_r.second == 8'd59) begin
            time_next.second = 8'd0;
            if (time_r.minute == 8'd59) begin
                time_next.minute = 8'd0;
                if (time_r.hour == 8'd23) begin
                    time_next.hour = 8'd0;   // midnight
                end else begin
                    time_next.hour = time_r.hour + 8'd1;
                end
            end else begin
                time_next.minute = time_r.minute + 8'd1;
            end
        end else begin
            time_next.second = time_r.second + 8'd1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            header_done_d <= 1'b0;
            tick_cnt      <= '0;
            sec_tick      <= 1'b0;
            time_r        <= '0;
        end else begin
            header_done_d <= header_done;
            sec_tick      <= 1'b0;
            if (load) begin
                time_r <= init_time;
            end
            if (header_done) begin
                if (tick_cnt == TICK_CNT_W'(CYCLES_PER_SECOND - 1)) begin
                    tick_cnt <= '0;
                    sec_tick <= 1'b1;
                    time_r   <= time_next;   // visible together with the pulse
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    // header start time must be legal, the wrap logic keeps it so
    a_sec_min_range: assert property (
        @(posedge clk) disable iff (reset)
        header_done |-> cur_time.second < 8'd60 && cur_time.minute < 8'd60
    ) else $error("second or minute out of range");

    a_hour_range: assert property (
        @(posedge clk) disable iff (reset)
        header_done |-> cur_time.hour < 8'd24
    ) else $error("hour out of range");

endmodule

// File: hdl/glyph_render.sv
`timescale 1ns/100ps

module glyph_render
    import dpa_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 header_done,
    input  logic                 sec_tick,
    input  time_t                cur_time,
    input  im_addr_t             fb_base,
    output logic [CR_ADDR_W-1:0] cr_a,
    input  logic [GLYPH_W-1:0]   cr_q,
    output im_addr_t             pix_a,
    output pixel_t               pix_d,
    output logic                 pix_wen
);

    logic                   header_done_d;
    logic                   start;
    logic                   busy;
    logic                   wr_phase;   // low for the ROM read cycle of a row
    logic [CHAR_CNT_W-1:0]  char_idx;
    logic [ROW_CNT_W-1:0]   row_idx;
    logic [BIT_CNT_W-1:0]   bit_idx;
    logic                   bit_last;
    logic                   row_last;
    logic                   char_last;
    logic [GLYPH_IDX_W-1:0] glyph_of [CHARS_PER_TIME];
    im_addr_t               win_line;
    im_addr_t               win_col;

    assign start     = (header_done & ~header_done_d) | sec_tick;
    assign bit_last  = (bit_idx == BIT_CNT_W'(GLYPH_W - 1));
    assign row_last  = (row_idx == ROW_CNT_W'(GLYPH_ROWS - 1));
    assign char_last = (char_idx == CHAR_CNT_W'(CHARS_PER_TIME - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            header_done_d <= 1'b0;
            busy          <= 1'b0;
            wr_phase      <= 1'b0;
            char_idx      <= '0;
            row_idx       <= '0;
            bit_idx       <= '0;
        end else begin
            header_done_d <= header_done;
            if (start) begin
                busy     <= 1'b1;
                wr_phase <= 1'b0;
                char_idx <= '0;
                row_idx  <= '0;
                bit_idx  <= '0;
            end else if (busy) begin
                if (!wr_phase) begin
                    wr_phase <= 1'b1;
                    bit_idx  <= '0;
                end else if (bit_last) begin
                    wr_phase <= 1'b0;
                    bit_idx  <= '0;
                    if (row_last) begin
                        row_idx <= '0;
                        if (char_last) begin
                            busy <= 1'b0;   // frame done
                        end else begin
                            char_idx <= char_idx + 1'b1;
                        end
                    end else begin
                        row_idx <= row_idx + 1'b1;
                    end
                end else begin
                    bit_idx <= bit_idx + 1'b1;
                end
            end
        end
    end

    // snapshot of the time as glyph indices, hh:mm:ss
    always_ff @(posedge clk) begin
        if (start) begin
            glyph_of[0] <= GLYPH_IDX_W'(cur_time.hour / 8'd10);
            glyph_of[1] <= GLYPH_IDX_W'(cur_time.hour % 8'd10);
            glyph_of[2] <= GLYPH_IDX_W'(GLYPH_COLON);
            glyph_of[3] <= GLYPH_IDX_W'(cur_time.minute / 8'd10);
            glyph_of[4] <= GLYPH_IDX_W'(cur_time.minute % 8'd10);
            glyph_of[5] <= GLYPH_IDX_W'(GLYPH_COLON);
            glyph_of[6] <= GLYPH_IDX_W'(cur_time.second / 8'd10);
            glyph_of[7] <= GLYPH_IDX_W'(cur_time.second % 8'd10);
        end
    end

    // held for the whole row, so cr_q stays valid through the writes
    assign cr_a = CR_ADDR_W'(glyph_of[char_idx]) * CR_ADDR_W'(GLYPH_ROWS)
                + CR_ADDR_W'(row_idx);

    assign win_line = im_addr_t'(TIME_ROW) + im_addr_t'(row_idx);
    assign win_col  = im_addr_t'(TIME_COL) + im_addr_t'(char_idx) * im_addr_t'(GLYPH_W)
                    + im_addr_t'(bit_idx);

    assign pix_a   = fb_base + win_line * im_addr_t'(FB_WIDTH) + win_col;
    assign pix_d   = cr_q[GLYPH_W - 1 - bit_idx] ? PIXEL_ON : PIXEL_OFF;   // msb leftmost
    assign pix_wen = ~(busy & wr_phase);

    // a frame must finish well inside one second
    a_no_tick_in_frame: assert property (
        @(posedge clk) disable iff (reset)
        sec_tick |-> !busy
    ) else $error("second tick during a frame");

endmodule

// File: hdl/dpa_top.sv
`timescale 1ns/100ps

module dpa_top
    import dpa_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    output im_addr_t             im_a,
    input  pixel_t               im_q,
    output pixel_t               im_d,
    output logic                 im_wen,
    output logic [CR_ADDR_W-1:0] cr_a,
    input  logic [GLYPH_W-1:0]   cr_q
);

    im_addr_t hdr_a;
    logic     hdr_wen;
    logic     header_done;
    time_t    init_time;
    im_addr_t fb_base;
    logic     sec_tick;
    time_t    cur_time;
    im_addr_t pix_a;
    pixel_t   pix_d;
    logic     pix_wen;

    header_decode decode_i (
        .clk         (clk),
        .reset       (reset),
        .im_q        (im_q),
        .hdr_a       (hdr_a),
        .hdr_wen     (hdr_wen),
        .header_done (header_done),
        .init_time   (init_time),
        .fb_base     (fb_base)
    );

    time_keeper keeper_i (
        .clk         (clk),
        .reset       (reset),
        .header_done (header_done),
        .init_time   (init_time),
        .sec_tick    (sec_tick),
        .cur_time    (cur_time)
    );

    glyph_render render_i (
        .clk         (clk),
        .reset       (reset),
        .header_done (header_done),
        .sec_tick    (sec_tick),
        .cur_time    (cur_time),
        .fb_base     (fb_base),
        .cr_a        (cr_a),
        .cr_q        (cr_q),
        .pix_a       (pix_a),
        .pix_d       (pix_d),
        .pix_wen     (pix_wen)
    );

    // header fetch owns the image port until the header is in
    assign im_a   = header_done ? pix_a : hdr_a;
    assign im_d   = header_done ? pix_d : PIXEL_OFF;
    assign im_wen = header_done ? pix_wen : hdr_wen;

endmodule

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 10;   // 20 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset goes high at once and drops just after the tenth rising edge
    task automatic hold_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;
    endtask

    initial hold_reset();

endmodule

// File: test/tb_memory.sv
`timescale 1ns/100ps

module tb_memory
    import dpa_pkg::*;
(
    input  logic                 clk,
    input  im_addr_t             im_a,
    output pixel_t               im_q,
    input  pixel_t               im_d,
    input  logic                 im_wen,
    input  logic [CR_ADDR_W-1:0] cr_a,
    output logic [GLYPH_W-1:0]   cr_q
);

    pixel_t             mem [1 << IM_ADDR_W];
    logic [GLYPH_W-1:0] rom [1 << CR_ADDR_W];
    im_addr_t           wr_addr_q [$];   // write log
    pixel_t             wr_data_q [$];
    time                wr_time_q [$];

    initial begin
        im_q = '0;
        cr_q = '0;
    end

    function automatic pixel_t fill_word(input im_addr_t a);
        return {a[3:0], a} ^ 24'h5a3c96;
    endfunction

    function automatic pixel_t read_word(input im_addr_t a);
        return mem[a];
    endfunction

    function automatic int write_count();
        return wr_addr_q.size();
    endfunction

    task automatic fill_all();
        int a;
        for (a = 0; a < (1 << IM_ADDR_W); a++) begin
            mem[a] = fill_word(im_addr_t'(a));
        end
        for (a = 0; a < (1 << CR_ADDR_W); a++) begin
            rom[a] = GLYPH_W'({a[3:0], a[CR_ADDR_W-1:0]});
        end
    endtask

    task automatic write_word(input im_addr_t a, input pixel_t d);
        mem[a] = d;
    endtask

    task automatic write_rom(input logic [CR_ADDR_W-1:0] a, input logic [GLYPH_W-1:0] d);
        rom[a] = d;
    endtask

    task automatic pop_write(output im_addr_t a, output pixel_t d, output time t);
        a = wr_addr_q.pop_front();
        d = wr_data_q.pop_front();
        t = wr_time_q.pop_front();
    endtask

    // both ports answer one cycle after the address
    always @(posedge clk) begin
        if (im_wen === 1'b0) begin
            mem[im_a] = im_d;
            wr_addr_q.push_back(im_a);
            wr_data_q.push_back(im_d);
            wr_time_q.push_back($time);
        end
        im_q <= #1 mem[im_a];
        cr_q <= #1 rom[cr_a];
    end

endmodule

// File: test/tb_top.sv
`timescale 1ns/100ps

module tb_top
    import dpa_pkg::*;
();

    localparam int FRAME_WRITES  = CHARS_PER_TIME * GLYPH_ROWS * GLYPH_W;
    localparam int FRAME_TIMEOUT = CYCLES_PER_SECOND + 3000;   // cycles
    localparam int ROM_WORDS     = (GLYPH_COLON + 1) * GLYPH_ROWS;
    localparam int BASE_RANGE    = 1040000;   // window stays inside memory

    logic                 clk;
    logic                 reset;
    im_addr_t             im_a;
    pixel_t               im_q;
    pixel_t               im_d;
    logic                 im_wen;
    logic [CR_ADDR_W-1:0] cr_a;
    logic [GLYPH_W-1:0]   cr_q;

    int unsigned        rng_state = 46;
    im_addr_t           base_addr;
    time_t              model_time;
    logic [GLYPH_W-1:0] rom_data [ROM_WORDS];
    logic [GLYPH_W-1:0] drawn [CHARS_PER_TIME][GLYPH_ROWS];   // decoded pixels

    tb_clock clk_i (.clk(clk), .reset(reset));

    tb_memory mem_i (
        .clk(clk), .im_a(im_a), .im_q(im_q), .im_d(im_d), .im_wen(im_wen),
        .cr_a(cr_a), .cr_q(cr_q)
    );

    dpa_top dut_i (
        .clk(clk), .reset(reset), .im_a(im_a), .im_q(im_q), .im_d(im_d),
        .im_wen(im_wen), .cr_a(cr_a), .cr_q(cr_q)
    );

    function automatic int unsigned next_random(input int unsigned range);
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return (rng_state >> 8) % range;
    endfunction

    function automatic time_t advance_time(input time_t t);
        time_t n;
        n = t;
        n.second = t.second + 8'd1;
        if (n.second == 8'd60) begin
            n.second = 8'd0;
            n.minute = t.minute + 8'd1;
        end
        if (n.minute == 8'd60) begin
            n.minute = 8'd0;
            n.hour   = t.hour + 8'd1;
        end
        if (n.hour == 8'd24)
            n.hour = 8'd0;
        return n;
    endfunction

    function automatic int glyph_for(input time_t t, input int c);
        case (c)
            0: return t.hour / 10;
            1: return t.hour % 10;
            3: return t.minute / 10;
            4: return t.minute % 10;
            6: return t.second / 10;
            7: return t.second % 10;
            default: return GLYPH_COLON;
        endcase
    endfunction

    // index of the ROM glyph that matches character c or 15 if none
    function automatic int decode_glyph(input int c);
        int  g;
        int  r;
        bit  hit;
        for (g = 0; g <= GLYPH_COLON; g++) begin
            hit = 1'b1;
            for (r = 0; r < GLYPH_ROWS; r++)
                if (drawn[c][r] !== rom_data[g * GLYPH_ROWS + r])
                    hit = 1'b0;
            if (hit)
                return g;
        end
        return 15;
    endfunction

    function automatic bit in_window(input im_addr_t a);
        int off;
        int line;
        int col;
        if (a < base_addr)
            return 1'b0;
        off  = int'(a - base_addr);
        line = off / FB_WIDTH;
        col  = off % FB_WIDTH;
        return line >= TIME_ROW && line < TIME_ROW + GLYPH_ROWS
            && col >= TIME_COL && col < TIME_COL + CHARS_PER_TIME * GLYPH_W;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pixel(input string name, input time at, input pixel_t got,
                               input pixel_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     at, name, got, exp));
    endtask

    task automatic check_addr(input string name, input time at, input im_addr_t got,
                              input im_addr_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0t: %s is %h, expected %h",
                                     at, name, got, exp));
    endtask

    task automatic check_time(input string name, input time at, input time_t got,
                              input time_t exp);
        if (got !== exp)
            report_failure($sformatf("mismatch at %0t: %s is %0d:%0d:%0d, expected %0d:%0d:%0d",
                                     at, name, got.hour, got.minute, got.second,
                                     exp.hour, exp.minute, exp.second));
    endtask

    task automatic build_stimulus();
        int    i;
        time_t start;
        mem_i.fill_all();
        for (i = 0; i < ROM_WORDS; i++) begin
            rom_data[i] = GLYPH_W'(next_random(1 << GLYPH_W));
            mem_i.write_rom(CR_ADDR_W'(i), rom_data[i]);
        end
        start.hour   = 8'(next_random(24));
        start.minute = 8'(next_random(60));
        start.second = 8'(next_random(60));
        base_addr    = im_addr_t'(16 + next_random(BASE_RANGE));
        mem_i.write_word(im_addr_t'(0), pixel_t'(start));
        mem_i.write_word(im_addr_t'(1), {4'(next_random(16)), base_addr});   // random pad
        model_time = start;
    endtask

    // returns at the first falling edge with reset low
    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (reset !== 1'b0 && n < 40);
        if (reset !== 1'b0)
            report_failure("reset was not released in time");
    endtask

    task automatic wait_frame_writes();
        int n;
        n = 0;
        while (mem_i.write_count() < FRAME_WRITES && n < FRAME_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (mem_i.write_count() < FRAME_WRITES)
            report_failure("timed out waiting for a complete frame of pixel writes");
    endtask

    task automatic check_header_fetch();
        if (mem_i.write_count() != 0)
            report_failure("a write occurred before the header fetch");
        if (im_wen !== 1'b1)
            report_failure("first access after reset is not a read");
        check_addr("im_a", $time, im_a, im_addr_t'(0));
        @(negedge clk);
        if (im_wen !== 1'b1)
            report_failure("second access after reset is not a read");
        check_addr("im_a", $time, im_a, im_addr_t'(1));
    endtask

    task automatic check_frame(input time_t exp_time);
        im_addr_t wr_a [FRAME_WRITES];
        pixel_t   wr_d [FRAME_WRITES];
        time      wr_t [FRAME_WRITES];
        im_addr_t exp_a;
        pixel_t   exp_d;
        int       n;
        int       c;
        int       r;
        int       k;
        int       g;
        int       dg [CHARS_PER_TIME];
        time_t    shown;
        wait_frame_writes();
        // writes come in character, row and bit order
        n = 0;
        for (c = 0; c < CHARS_PER_TIME; c++) begin
            for (r = 0; r < GLYPH_ROWS; r++) begin
                for (k = 0; k < GLYPH_W; k++) begin
                    mem_i.pop_write(wr_a[n], wr_d[n], wr_t[n]);
                    drawn[c][r][GLYPH_W - 1 - k] = (wr_d[n] === PIXEL_ON);
                    n++;
                end
            end
        end
        for (c = 0; c < CHARS_PER_TIME; c++)
            dg[c] = decode_glyph(c);
        if (dg[2] != GLYPH_COLON || dg[5] != GLYPH_COLON)
            report_failure("the colons were not drawn between the time fields");
        shown.hour   = 8'(dg[0] * 10 + dg[1]);
        shown.minute = 8'(dg[3] * 10 + dg[4]);
        shown.second = 8'(dg[6] * 10 + dg[7]);
        check_time("drawn time", $time, shown, exp_time);
        n = 0;
        for (c = 0; c < CHARS_PER_TIME; c++) begin
            g = glyph_for(exp_time, c);
            for (r = 0; r < GLYPH_ROWS; r++) begin
                for (k = 0; k < GLYPH_W; k++) begin
                    exp_a = base_addr + im_addr_t'((TIME_ROW + r) * FB_WIDTH
                                                   + TIME_COL + c * GLYPH_W + k);
                    exp_d = rom_data[g * GLYPH_ROWS + r][GLYPH_W - 1 - k] ? PIXEL_ON
                                                                          : PIXEL_OFF;
                    check_addr("im_a", wr_t[n], wr_a[n], exp_a);
                    check_pixel("im_d", wr_t[n], wr_d[n], exp_d);
                    n++;
                end
            end
        end
    endtask

    // nothing outside the window may differ from the fill pattern
    task automatic scan_outside_window();
        int     a;
        pixel_t got;
        pixel_t exp;
        for (a = HEADER_WORDS; a < (1 << IM_ADDR_W); a++) begin
            if (!in_window(im_addr_t'(a))) begin
                got = mem_i.read_word(im_addr_t'(a));
                exp = mem_i.fill_word(im_addr_t'(a));
                if (got !== exp)
                    check_pixel($sformatf("mem[%h]", a), $time, got, exp);
            end
        end
    endtask

    initial begin
        build_stimulus();
        wait_reset_release();
        check_header_fetch();
        check_frame(model_time);
        repeat (3) begin
            model_time = advance_time(model_time);
            check_frame(model_time);
        end

        // second run across midnight
        mem_i.write_word(im_addr_t'(0), {8'd23, 8'd59, 8'd58});
        @(posedge clk);
        #1;
        clk_i.hold_reset();
        wait_reset_release();
        check_header_fetch();
        check_frame({8'd23, 8'd59, 8'd58});
        check_frame({8'd23, 8'd59, 8'd59});
        check_frame({8'd0, 8'd0, 8'd0});

        scan_outside_window();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: files.f
hdl/dpa_pkg.sv
hdl/header_decode.sv
hdl/time_keeper.sv
hdl/glyph_render.sv
hdl/dpa_top.sv
test/tb_clock.sv
test/tb_memory.sv
test/tb_top.sv

// File: Bender.yml
package:
  name: dpa_clock_overlay

sources:
  - hdl/dpa_pkg.sv
  - hdl/header_decode.sv
  - hdl/time_keeper.sv
  - hdl/glyph_render.sv
  - hdl/dpa_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_memory.sv
      - test/tb_top.sv
